// ==== src/lsuPkg.sv ====
// Shared encodings and widths for the load/store unit and its data cache
`default_nettype none

package lsuPkg;

    localparam int WordWidth = 32;

    typedef enum logic [2:0] {
        CmdNone             = 3'd0,
        CmdLoad             = 3'd1,
        CmdStore            = 3'd2,
        CmdAtomic           = 3'd3,
        CmdLoadReserved     = 3'd4,
        CmdStoreConditional = 3'd5,
        CmdInvalidate       = 3'd6
    } lsuCmd_t;

    // Low bits give the width, bit 2 marks zero extension
    typedef enum logic [2:0] {
        SizeByte  = 3'd0,
        SizeHalf  = 3'd1,
        SizeWord  = 3'd2,
        SizeByteU = 3'd4,
        SizeHalfU = 3'd5
    } memSize_t;

    typedef enum logic [3:0] {
        AtomicSwap = 4'd0,
        AtomicAdd  = 4'd1,
        AtomicXor  = 4'd2,
        AtomicAnd  = 4'd3,
        AtomicOr   = 4'd4,
        AtomicMin  = 4'd5,
        AtomicMax  = 4'd6,
        AtomicMinu = 4'd7,
        AtomicMaxu = 4'd8
    } atomicOp_t;

    // Controller to line replacer
    typedef enum logic [1:0] {
        ReplNone         = 2'd0,
        ReplRefill       = 2'd1,
        ReplWriteThrough = 2'd2,
        ReplInvalidate   = 2'd3
    } replacerCmd_t;

endpackage

`default_nettype wire

// ==== src/cacheRam.sv ====
// Single-port synchronous RAM for cache tags or lines, optionally cleared by reset
`timescale 1ns/1ps
`default_nettype none

module cacheRam #(
    parameter type payload_t = logic [31:0],
    parameter int IndexWidth = 4,
    parameter bit ClearOnReset = 1'b0
) (
    input  logic clk,
    input  logic rst,
    input  logic [IndexWidth-1:0] index,
    input  logic writeEnable,
    input  payload_t writeValue,
    output payload_t readValue
);
    payload_t mem [2**IndexWidth];

    // Write-first, a written entry shows up on the next cycle
    always_ff @(posedge clk) begin
        if (ClearOnReset && rst) begin
            for (int i = 0; i < 2**IndexWidth; i++) begin
                mem[i] <= '0;
            end
            readValue <= '0;
        end else if (writeEnable) begin
            mem[index] <= writeValue;
            readValue <= writeValue;
        end else begin
            readValue <= mem[index];
        end
    end

endmodule

`default_nettype wire

// ==== src/lineDataPath.sv ====
// Load extraction, store merge and atomic ALU on a cache line
`timescale 1ns/1ps
`default_nettype none

module lineDataPath #(
    parameter int LineBytes = 16,
    localparam int OffsetWidth = $clog2(LineBytes),
    localparam int LineWidth = LineBytes * 8
) (
    input  logic [LineWidth-1:0] line,
    input  logic [OffsetWidth-1:0] offset,
    input  lsuPkg::memSize_t size,
    input  lsuPkg::atomicOp_t atomicOp,
    input  logic isAtomic,
    input  logic [lsuPkg::WordWidth-1:0] storeValue,
    output logic [lsuPkg::WordWidth-1:0] loadValue,
    output logic [LineWidth-1:0] mergedLine
);
    logic [LineWidth-1:0] shiftedLine;
    logic [lsuPkg::WordWidth-1:0] rawWord;
    logic [lsuPkg::WordWidth-1:0] operand;
    logic [3:0] sizeMask;
    logic [LineBytes-1:0] writeMask;
    logic [LineWidth-1:0] operandLine;

    function automatic logic [lsuPkg::WordWidth-1:0] atomicAlu(
        input lsuPkg::atomicOp_t op,
        input logic [lsuPkg::WordWidth-1:0] regValue,
        input logic [lsuPkg::WordWidth-1:0] memValue
    );
        unique case (op)
            lsuPkg::AtomicSwap: return regValue;
            lsuPkg::AtomicAdd: return regValue + memValue;
            lsuPkg::AtomicXor: return regValue ^ memValue;
            lsuPkg::AtomicAnd: return regValue & memValue;
            lsuPkg::AtomicOr: return regValue | memValue;
            lsuPkg::AtomicMin: return ($signed(regValue) < $signed(memValue)) ? regValue : memValue;
            lsuPkg::AtomicMax: return ($signed(regValue) > $signed(memValue)) ? regValue : memValue;
            lsuPkg::AtomicMinu: return (regValue < memValue) ? regValue : memValue;
            lsuPkg::AtomicMaxu: return (regValue > memValue) ? regValue : memValue;
            default: return memValue;
        endcase
    endfunction

    // Address is naturally aligned, so a word never runs past the line
    assign shiftedLine = line >> {offset, 3'b000};
    assign rawWord = shiftedLine[lsuPkg::WordWidth-1:0];

    always_comb begin
        unique case (size)
            lsuPkg::SizeByte: loadValue = {{(lsuPkg::WordWidth-8){rawWord[7]}}, rawWord[7:0]};
            lsuPkg::SizeHalf: loadValue = {{(lsuPkg::WordWidth-16){rawWord[15]}}, rawWord[15:0]};
            lsuPkg::SizeByteU: loadValue = {{(lsuPkg::WordWidth-8){1'b0}}, rawWord[7:0]};
            lsuPkg::SizeHalfU: loadValue = {{(lsuPkg::WordWidth-16){1'b0}}, rawWord[15:0]};
            default: loadValue = rawWord;
        endcase
    end

    always_comb begin
        unique case (size)
            lsuPkg::SizeByte, lsuPkg::SizeByteU: sizeMask = 4'b0001;
            lsuPkg::SizeHalf, lsuPkg::SizeHalfU: sizeMask = 4'b0011;
            default: sizeMask = 4'b1111;
        endcase
    end

    // Atomics store the ALU result of the operand and the old word
    assign operand = isAtomic ? atomicAlu(atomicOp, storeValue, loadValue) : storeValue;
    assign writeMask = LineBytes'(sizeMask) << offset;
    assign operandLine = LineWidth'(operand) << {offset, 3'b000};

    always_comb begin
        for (int i = 0; i < LineBytes; i++) begin
            mergedLine[i*8 +: 8] = writeMask[i] ? operandLine[i*8 +: 8] : line[i*8 +: 8];
        end
    end

endmodule

`default_nettype wire

// ==== src/lineReplacer.sv ====
// Line replacer for refill, write-through and invalidate sweeps against memory
`timescale 1ns/1ps
`default_nettype none

module lineReplacer #(
    parameter int LineBytes = 16,
    parameter int IndexWidth = 4,
    parameter int AddrWidth = 16,
    localparam int OffsetWidth = $clog2(LineBytes),
    localparam int LineAddrWidth = AddrWidth - OffsetWidth,
    localparam int TagWidth = LineAddrWidth - IndexWidth,
    localparam int LineWidth = LineBytes * 8
) (
    input  logic clk,
    input  logic rst,
    input  lsuPkg::replacerCmd_t cmd,
    input  logic [LineAddrWidth-1:0] lineAddr,
    output logic done,
    output logic [IndexWidth-1:0] arrayIndex,
    output logic arrayTagWrite,
    output logic arrayTagValid,
    output logic [TagWidth-1:0] arrayTag,
    output logic [LineWidth-1:0] arrayLine,
    input  logic [LineWidth-1:0] currentLine,
    output logic [LineAddrWidth-1:0] memAddr,
    output logic memReadReq,
    input  logic memReadGrant,
    input  logic [LineWidth-1:0] memReadValue,
    output logic memWriteReq,
    input  logic memWriteGrant,
    output logic [LineWidth-1:0] memWriteValue
);
    logic [IndexWidth-1:0] sweepIndex;
    logic sweeping;

    assign sweeping = (cmd == lsuPkg::ReplInvalidate);

    // One entry per cycle, wraps to zero after the last one
    always_ff @(posedge clk) begin
        if (rst) begin
            sweepIndex <= '0;
        end else if (sweeping) begin
            sweepIndex <= sweepIndex + 1'b1;
        end
    end

    // Requests stay up as long as the controller holds the command
    assign memAddr = lineAddr;
    assign memReadReq = (cmd == lsuPkg::ReplRefill);
    assign memWriteReq = (cmd == lsuPkg::ReplWriteThrough);
    assign memWriteValue = currentLine;

    // Refill data goes into the arrays in the grant cycle
    assign arrayIndex = sweeping ? sweepIndex : lineAddr[IndexWidth-1:0];
    assign arrayTagWrite = sweeping || (memReadReq && memReadGrant);
    assign arrayTagValid = !sweeping;
    assign arrayTag = sweeping ? '0 : lineAddr[LineAddrWidth-1:IndexWidth];
    assign arrayLine = memReadValue;

    always_comb begin
        unique case (cmd)
            lsuPkg::ReplRefill: done = memReadGrant;
            lsuPkg::ReplWriteThrough: done = memWriteGrant;
            lsuPkg::ReplInvalidate: done = &sweepIndex;
            default: done = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/lsuControl.sv ====
// Controller that sequences cache lookups, stores, reservations and replacer commands
`timescale 1ns/1ps
`default_nettype none

module lsuControl #(
    parameter int LineBytes = 16,
    parameter int IndexWidth = 4,
    parameter int AddrWidth = 16,
    localparam int OffsetWidth = $clog2(LineBytes),
    localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth,
    localparam int LineWidth = LineBytes * 8
) (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  lsuPkg::lsuCmd_t cmd,
    input  lsuPkg::memSize_t size,
    input  logic [lsuPkg::WordWidth-1:0] base,
    input  logic [lsuPkg::WordWidth-1:0] imm,
    output logic done,
    output logic [lsuPkg::WordWidth-1:0] result,
    output logic [AddrWidth-1:0] resultAddr,
    output logic [IndexWidth-1:0] tagIndex,
    output logic tagWriteEnable,
    output logic [TagWidth+1:0] tagWriteValue,
    input  logic [TagWidth+1:0] tagReadValue,
    output logic [IndexWidth-1:0] dataIndex,
    output logic dataWriteEnable,
    output logic [LineWidth-1:0] dataWriteValue,
    input  logic [LineWidth-1:0] dataReadValue,
    output lsuPkg::replacerCmd_t replacerCmd,
    input  logic replacerDone,
    input  logic [IndexWidth-1:0] replacerIndex,
    input  logic replacerTagWrite,
    input  logic [TagWidth+1:0] replacerTagValue,
    input  logic [LineWidth-1:0] replacerLine,
    input  logic [lsuPkg::WordWidth-1:0] loadValue,
    input  logic [LineWidth-1:0] mergedLine
);
    typedef enum logic [2:0] {
        Idle, Lookup, Store, WriteThrough, Refill, Reserve, Invalidate
    } state_t;

    state_t state;
    state_t nextState;
    logic [AddrWidth-1:0] addrSum;
    logic [AddrWidth-1:0] newAddr;
    logic [AddrWidth-1:0] addrReg;
    logic [lsuPkg::WordWidth-1:0] oldValue;
    logic [IndexWidth-1:0] arrayIndex;
    logic useReplacer;
    logic hit;
    logic reserved;

    assign addrSum = AddrWidth'(base + imm);

    // Natural alignment, bits below the access size are dropped
    always_comb begin
        if (size == lsuPkg::SizeWord) begin
            newAddr = {addrSum[AddrWidth-1:2], 2'b00};
        end else if (size == lsuPkg::SizeHalf || size == lsuPkg::SizeHalfU) begin
            newAddr = {addrSum[AddrWidth-1:1], 1'b0};
        end else begin
            newAddr = addrSum;
        end
    end

    assign hit = tagReadValue[TagWidth+1]
        && tagReadValue[TagWidth-1:0] == addrReg[AddrWidth-1 -: TagWidth];
    assign reserved = tagReadValue[TagWidth];

    always_comb begin
        nextState = state;
        unique case (state)
            Idle: begin
                if (enable && cmd == lsuPkg::CmdInvalidate) begin
                    nextState = Invalidate;
                end else if (enable && cmd != lsuPkg::CmdNone) begin
                    nextState = Lookup;
                end
            end
            Lookup: begin
                if (!hit) begin
                    nextState = Refill;
                end else if (cmd == lsuPkg::CmdLoad) begin
                    nextState = Idle;
                end else if (cmd == lsuPkg::CmdLoadReserved) begin
                    nextState = Reserve;
                end else if (cmd == lsuPkg::CmdStoreConditional && !reserved) begin
                    nextState = Idle;
                end else begin
                    nextState = Store;
                end
            end
            Store: nextState = WriteThrough;
            Reserve: nextState = Idle;
            // Retry the lookup once the line is in
            Refill: nextState = replacerDone ? Lookup : Refill;
            WriteThrough, Invalidate: nextState = replacerDone ? Idle : state;
            default: nextState = Idle;
        endcase
    end

    assign done = (state == Idle && enable && cmd == lsuPkg::CmdNone)
        || (state == Lookup && hit && cmd == lsuPkg::CmdLoad)
        || (state == Lookup && hit && cmd == lsuPkg::CmdStoreConditional && !reserved)
        || state == Reserve
        || ((state == WriteThrough || state == Invalidate) && replacerDone);

    always_comb begin
        unique case (cmd)
            lsuPkg::CmdLoad: result = loadValue;
            lsuPkg::CmdAtomic, lsuPkg::CmdLoadReserved: result = oldValue;
            lsuPkg::CmdStoreConditional: result = (state == WriteThrough) ? '0 : 1;
            default: result = '0;
        endcase
    end

    always_comb begin
        unique case (state)
            Refill: replacerCmd = lsuPkg::ReplRefill;
            WriteThrough: replacerCmd = lsuPkg::ReplWriteThrough;
            Invalidate: replacerCmd = lsuPkg::ReplInvalidate;
            default: replacerCmd = lsuPkg::ReplNone;
        endcase
    end

    // Arrays follow the replacer during refill and sweep
    assign useReplacer = (state == Refill || state == Invalidate);
    assign arrayIndex = useReplacer ? replacerIndex
        : (state == Idle) ? newAddr[OffsetWidth +: IndexWidth]
        : addrReg[OffsetWidth +: IndexWidth];
    assign tagIndex = arrayIndex;
    assign dataIndex = arrayIndex;

    assign tagWriteEnable = useReplacer ? replacerTagWrite : (state == Reserve || state == Store);
    // Reserve sets the reservation, any store clears it
    assign tagWriteValue = useReplacer ? replacerTagValue
        : {tagReadValue[TagWidth+1], state == Reserve, tagReadValue[TagWidth-1:0]};

    // Skip the array write when the merge leaves the line as it was
    assign dataWriteEnable = (state == Refill && replacerTagWrite)
        || (state == Store && mergedLine != dataReadValue);
    assign dataWriteValue = (state == Refill) ? replacerLine : mergedLine;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == Idle && enable) begin
            addrReg <= newAddr;
        end
        if (state == Lookup) begin
            oldValue <= loadValue;
        end
    end

    assign resultAddr = addrReg;

endmodule

`default_nettype wire

// ==== src/loadStoreUnit.sv ====
// Load/store unit with a direct-mapped write-through data cache
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit #(
    parameter int LineBytes = 16,
    parameter int IndexWidth = 4,
    parameter int AddrWidth = 16,
    localparam int OffsetWidth = $clog2(LineBytes),
    localparam int LineWidth = LineBytes * 8
) (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  lsuPkg::lsuCmd_t cmd,
    input  lsuPkg::memSize_t size,
    input  lsuPkg::atomicOp_t atomicOp,
    input  logic [lsuPkg::WordWidth-1:0] base,
    input  logic [lsuPkg::WordWidth-1:0] imm,
    input  logic [lsuPkg::WordWidth-1:0] storeValue,
    output logic done,
    output logic [lsuPkg::WordWidth-1:0] result,
    output logic [AddrWidth-1:0] resultAddr,
    output logic [AddrWidth-OffsetWidth-1:0] memAddr,
    output logic memReadReq,
    output logic memWriteReq,
    output logic [LineWidth-1:0] memWriteValue,
    input  logic memReadGrant,
    input  logic memWriteGrant,
    input  logic [LineWidth-1:0] memReadValue
);
    localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth;

    // Valid, reserved, then the tag
    typedef logic [TagWidth+1:0] tagEntry_t;
    typedef logic [LineWidth-1:0] line_t;

    logic [IndexWidth-1:0] tagIndex;
    logic tagWriteEnable;
    tagEntry_t tagWriteValue;
    tagEntry_t tagReadValue;
    logic [IndexWidth-1:0] dataIndex;
    logic dataWriteEnable;
    line_t dataWriteValue;
    line_t dataReadValue;
    lsuPkg::replacerCmd_t replacerCmd;
    logic replacerDone;
    logic [IndexWidth-1:0] replacerIndex;
    logic replacerTagWrite;
    logic replacerTagValid;
    logic [TagWidth-1:0] replacerTag;
    line_t replacerLine;
    logic [lsuPkg::WordWidth-1:0] loadValue;
    line_t mergedLine;

    lsuControl #(
        .LineBytes(LineBytes),
        .IndexWidth(IndexWidth),
        .AddrWidth(AddrWidth)
    ) control_i (
        .clk, .rst, .enable, .cmd, .size, .base, .imm, .done, .result, .resultAddr,
        .tagIndex, .tagWriteEnable, .tagWriteValue, .tagReadValue,
        .dataIndex, .dataWriteEnable, .dataWriteValue, .dataReadValue,
        .replacerCmd, .replacerDone, .replacerIndex, .replacerTagWrite,
        .replacerTagValue({replacerTagValid, 1'b0, replacerTag}),
        .replacerLine, .loadValue, .mergedLine
    );

    cacheRam #(
        .payload_t(tagEntry_t),
        .IndexWidth(IndexWidth),
        .ClearOnReset(1'b1)
    ) tagRam_i (
        .clk, .rst,
        .index(tagIndex),
        .writeEnable(tagWriteEnable),
        .writeValue(tagWriteValue),
        .readValue(tagReadValue)
    );

    cacheRam #(
        .payload_t(line_t),
        .IndexWidth(IndexWidth),
        .ClearOnReset(1'b0)
    ) dataRam_i (
        .clk, .rst,
        .index(dataIndex),
        .writeEnable(dataWriteEnable),
        .writeValue(dataWriteValue),
        .readValue(dataReadValue)
    );

    lineReplacer #(
        .LineBytes(LineBytes),
        .IndexWidth(IndexWidth),
        .AddrWidth(AddrWidth)
    ) replacer_i (
        .clk, .rst,
        .cmd(replacerCmd),
        .lineAddr(resultAddr[AddrWidth-1:OffsetWidth]),
        .done(replacerDone),
        .arrayIndex(replacerIndex),
        .arrayTagWrite(replacerTagWrite),
        .arrayTagValid(replacerTagValid),
        .arrayTag(replacerTag),
        .arrayLine(replacerLine),
        .currentLine(dataReadValue),
        .memAddr, .memReadReq, .memReadGrant, .memReadValue,
        .memWriteReq, .memWriteGrant, .memWriteValue
    );

    lineDataPath #(
        .LineBytes(LineBytes)
    ) dataPath_i (
        .line(dataReadValue),
        .offset(resultAddr[OffsetWidth-1:0]),
        .size, .atomicOp,
        .isAtomic(cmd == lsuPkg::CmdAtomic),
        .storeValue, .loadValue, .mergedLine
    );

endmodule

`default_nettype wire

// ==== test/lsuAssert_assert.sv ====
// Protocol assertions on the memory requests and the done pulse
`timescale 1ns/1ps
`default_nettype none

module lsuAssert (
    input wire clk,
    input wire rst,
    input wire done,
    input wire memReadReq,
    input wire memWriteReq,
    input wire memReadGrant,
    input wire memWriteGrant
);
    readHeld: assert property (@(posedge clk) disable iff (rst)
        memReadReq && !memReadGrant |=> memReadReq)
        else $error("read request dropped before its grant");

    writeHeld: assert property (@(posedge clk) disable iff (rst)
        memWriteReq && !memWriteGrant |=> memWriteReq)
        else $error("write request dropped before its grant");

    noOverlap: assert property (@(posedge clk) disable iff (rst)
        !(memReadReq && memWriteReq))
        else $error("read and write requested together");

    donePulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held for more than one cycle");

endmodule

`default_nettype wire

// ==== test/lsuChecker.sv ====
// Monitor that checks result, address and latency of each completed operation
`timescale 1ns/1ps
`default_nettype none

module lsuChecker #(
    parameter int AddrWidth = 16
) (
    input  wire clk,
    input  wire rst,
    input  wire enable,
    input  wire lsuPkg::lsuCmd_t cmd,
    input  wire done,
    input  wire [31:0] result,
    input  wire [AddrWidth-1:0] resultAddr,
    input  wire [31:0] expectedResult,
    input  wire [AddrWidth-1:0] expectedAddr,
    input  wire [31:0] expectedLatency,
    output int errorCount,
    output int doneCount
);
    logic busy;
    int cycles;

    initial begin
        errorCount = 0;
        doneCount = 0;
        busy = 1'b0;
        cycles = 0;
    end

    // Sampled mid-cycle, when done and result are settled
    always @(negedge clk) begin
        if (rst) begin
            busy = 1'b0;
        end else begin
            if (enable) begin
                busy = 1'b1;
                cycles = 0;
            end else if (busy) begin
                cycles = cycles + 1;
            end
            if (done) begin
                doneCount = doneCount + 1;
                if (!busy) begin
                    $display("Done pulsed at %0t with no operation in flight", $time);
                    errorCount = errorCount + 1;
                end
                if (result !== expectedResult) begin
                    $display("FAIL %0t result expected %h got %h",
                        $time, expectedResult, result);
                    errorCount = errorCount + 1;
                end
                if (resultAddr !== expectedAddr) begin
                    $display("FAIL %0t resultAddr expected %h got %h",
                        $time, expectedAddr, resultAddr);
                    errorCount = errorCount + 1;
                end
                // Zero means the latency depends on memory, so such a load has to miss
                if (expectedLatency != 0 && cycles != expectedLatency) begin
                    $display("FAIL %0t done latency expected %0d got %0d",
                        $time, expectedLatency, cycles);
                    errorCount = errorCount + 1;
                end else if (expectedLatency == 0 && cmd == lsuPkg::CmdLoad && cycles < 2) begin
                    $display("FAIL %0t done latency expected more than 1 got %0d",
                        $time, cycles);
                    errorCount = errorCount + 1;
                end
                busy = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/lsuTb.sv ====
// Testbench for the load/store unit with a line-wide memory model and pattern driver
`timescale 1ns/1ps
`default_nettype none

module lsuTb;
    localparam int LineBytes = 16;
    localparam int IndexWidth = 4;
    localparam int AddrWidth = 16;
    localparam int LineWidth = LineBytes * 8;
    localparam int OffsetWidth = $clog2(LineBytes);
    localparam int Fields = 8;
    localparam int MaxPatterns = 64;

    logic clk = 1'b0;
    logic rst;
    logic enable;
    lsuPkg::lsuCmd_t cmd;
    lsuPkg::memSize_t size;
    lsuPkg::atomicOp_t atomicOp;
    logic [31:0] base;
    logic [31:0] imm;
    logic [31:0] storeValue;
    wire done;
    wire [31:0] result;
    wire [AddrWidth-1:0] resultAddr;
    wire [AddrWidth-OffsetWidth-1:0] memAddr;
    wire memReadReq;
    wire memWriteReq;
    wire [LineWidth-1:0] memWriteValue;
    logic memReadGrant;
    logic memWriteGrant;
    logic [LineWidth-1:0] memReadValue;
    logic [31:0] expectedResult;
    logic [31:0] expectedLatency;
    logic [AddrWidth-1:0] expectedAddr;
    int errorCount;
    int doneCount;

    logic [31:0] patterns [0:Fields*MaxPatterns-1];
    logic [7:0] memory [0:2**AddrWidth-1];
    int patternCount;
    int cycleCount = 0;
    int cycleLimit = 1000000;
    int seed = 32'h5e9e_eb17;
    int waitCount;
    logic waiting;

    always #2 clk = ~clk;

    loadStoreUnit #(
        .LineBytes(LineBytes),
        .IndexWidth(IndexWidth),
        .AddrWidth(AddrWidth)
    ) dut_i (
        .clk, .rst, .enable, .cmd, .size, .atomicOp, .base, .imm, .storeValue,
        .done, .result, .resultAddr, .memAddr, .memReadReq, .memWriteReq,
        .memWriteValue, .memReadGrant, .memWriteGrant, .memReadValue
    );

    lsuChecker #(
        .AddrWidth(AddrWidth)
    ) checker_i (
        .clk, .rst, .enable, .cmd, .done, .result, .resultAddr,
        .expectedResult, .expectedAddr, .expectedLatency,
        .errorCount, .doneCount
    );

    bind loadStoreUnit lsuAssert assert_i (
        .clk, .rst, .done, .memReadReq, .memWriteReq, .memReadGrant, .memWriteGrant
    );

    // Memory model, grants each request after a random delay
    always @(posedge clk) begin
        #0.5;
        memReadGrant = 1'b0;
        memWriteGrant = 1'b0;
        if (rst) begin
            waiting = 1'b0;
        end else if (memReadReq || memWriteReq) begin
            if (!waiting) begin
                waiting = 1'b1;
                waitCount = 1 + ({$random(seed)} % 4);
            end
            waitCount = waitCount - 1;
            if (waitCount == 0) begin
                waiting = 1'b0;
                for (int k = 0; k < LineBytes; k++) begin
                    if (memReadReq) begin
                        memReadValue[k*8 +: 8] = memory[{memAddr, OffsetWidth'(0)} + k];
                    end else begin
                        memory[{memAddr, OffsetWidth'(0)} + k] = memWriteValue[k*8 +: 8];
                    end
                end
                memReadGrant = memReadReq;
                memWriteGrant = !memReadReq;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, the unit never signaled done", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int invalidates;
        rst = 1'b1;
        enable = 1'b0;
        cmd = lsuPkg::CmdNone;
        size = lsuPkg::SizeWord;
        atomicOp = lsuPkg::AtomicSwap;
        base = '0;
        imm = '0;
        storeValue = '0;
        memReadGrant = 1'b0;
        memWriteGrant = 1'b0;
        memReadValue = '0;
        expectedResult = '0;
        expectedLatency = '0;
        expectedAddr = '0;
        waiting = 1'b0;
        waitCount = 0;
        for (int a = 0; a < 2**AddrWidth; a++) begin
            memory[a] = 8'(a) ^ 8'hA5;
        end
        // Entries past the last line keep the all-ones marker
        for (int i = 0; i < Fields*MaxPatterns; i++) begin
            patterns[i] = '1;
        end
        $readmemh("test/lsuPatterns.hex", patterns);
        patternCount = 0;
        invalidates = 0;
        while (patternCount < MaxPatterns && patterns[patternCount*Fields] !== '1) begin
            if (patterns[patternCount*Fields] == 32'(lsuPkg::CmdInvalidate)) begin
                invalidates++;
            end
            patternCount++;
        end
        cycleLimit = 200 * patternCount + invalidates * (2**IndexWidth) + 20;

        repeat (10) @(posedge clk);
        #0.5 rst = 1'b0;

        for (int p = 0; p < patternCount; p++) begin
            @(posedge clk);
            #0.5;
            cmd = lsuPkg::lsuCmd_t'(patterns[p*Fields][2:0]);
            size = lsuPkg::memSize_t'(patterns[p*Fields+1][2:0]);
            atomicOp = lsuPkg::atomicOp_t'(patterns[p*Fields+2][3:0]);
            base = patterns[p*Fields+3];
            imm = patterns[p*Fields+4];
            storeValue = patterns[p*Fields+5];
            expectedResult = patterns[p*Fields+6];
            expectedLatency = patterns[p*Fields+7];
            // Effective address is base plus immediate
            expectedAddr = AddrWidth'(base + imm);
            enable = 1'b1;
            @(posedge clk);
            #0.5 enable = 1'b0;
            do begin
                @(negedge clk);
            end while (!done);
        end

        @(posedge clk);
        $display("Closing: %0d errors in %0d operations", errorCount, doneCount);
        if (errorCount == 0 && doneCount == patternCount) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/lsuPatterns.hex ====
// cmd size atomicOp base imm storeValue expectedResult expectedLatency
// Latency is cycles from enable to done, 0 when it depends on memory
1 2 0 00000100 00000000 00000000 A6A7A4A5 0
1 2 0 00000100 00000004 00000000 A2A3A0A1 1
1 0 0 00000100 00000005 00000000 FFFFFFA0 1
1 4 0 00000100 00000005 00000000 000000A0 1
1 1 0 00000200 0000002A 00000000 FFFF8E8F 0
1 5 0 00000200 0000002E 00000000 00008A8B 1
1 0 0 00000243 FFFFFFF0 00000000 FFFFFF96 0
2 0 0 00000100 00000006 0000005C 00000000 0
1 2 0 00000100 00000004 00000000 A25CA0A1 1
6 0 0 00000000 00000000 00000000 00000000 10
1 2 0 00000104 00000000 00000000 A25CA0A1 0
3 2 0 00000300 00000000 00000010 A6A7A4A5 0
3 2 1 00000300 00000000 00000005 00000010 0
3 2 2 00000300 00000000 000000FF 00000015 0
3 2 3 00000300 00000000 0000000F 000000EA 0
3 2 4 00000300 00000000 80000000 0000000A 0
3 2 5 00000300 00000000 80000000 8000000A 0
3 2 6 00000300 00000000 00000007 80000000 0
3 2 7 00000300 00000000 00000002 00000007 0
3 2 8 00000300 00000000 90000000 00000002 0
1 2 0 00000300 00000000 00000000 90000000 1
4 2 0 00000400 00000000 00000000 A6A7A4A5 0
5 2 0 00000400 00000000 12345678 00000000 0
1 2 0 00000400 00000000 00000000 12345678 1
4 2 0 00000400 00000000 00000000 12345678 0
2 2 0 00000400 00000004 CAFEF00D 00000000 0
5 2 0 00000400 00000000 DEADBEEF 00000001 0
1 2 0 00000400 00000000 00000000 12345678 1
6 0 0 00000000 00000000 00000000 00000000 10
1 2 0 00000400 00000000 00000000 12345678 0

// ==== project.f ====
src/lsuPkg.sv
src/cacheRam.sv
src/lineDataPath.sv
src/lineReplacer.sv
src/lsuControl.sv
src/loadStoreUnit.sv
test/lsuAssert_assert.sv
test/lsuChecker.sv
test/lsuTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= lsuTb
FILE_LIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_TEXT ?= Test failed
PASS_TEXT ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
